// ==== files.f ====
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/rv_pipe_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/rv_core_top.sv
test/rv_core_assert.sv
test/rv_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qxF '** PASS **' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/rv_core_tb.sv ====
`timescale 1ns/1ns
`include "rv_core_params.svh"

module rv_core_tb
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
();

  logic                clk_i;
  logic                rst_n_i;
  logic                inst_valid_i;
  rv_inst_t            inst_i;
  logic                wb_valid_o;
  wb_t                 wb_o;

  logic [`RV_XLEN-1:0] model_regs [`RV_NUM_REGS];
  logic [31:0]         rng_state;
  wb_t                 exp_q [$];
  int                  exp_cyc_q [$];
  int                  cycle_cnt;
  int                  err_cnt;
  int                  check_cnt;
  int                  test_err_base;
  int                  tests_run;
  int                  tests_failed;
  string               cur_test;

  rv_core_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  // ======================================================================
  // stimulus helpers
  // ======================================================================
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [4:0] rand_reg();
    logic [31:0] r;
    r = next_rand();
    return (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
  endfunction

  function automatic rv_inst_t r_inst(logic [2:0] f3, logic alt, logic [4:0] rd,
                                      logic [4:0] rs1, logic [4:0] rs2);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic rv_inst_t i_inst(logic [2:0] f3, logic [11:0] imm, logic [4:0] rd,
                                      logic [4:0] rs1);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  function automatic rv_inst_t u_inst(logic [19:0] imm, logic [4:0] rd);
    return {imm, rd, OPC_LUI};
  endfunction

  function automatic rv_inst_t rand_inst();
    logic [31:0] r;
    rv_inst_t    inst;
    r = next_rand();
    inst = next_rand();
    inst.opcode = (r[1:0] == 2'd0) ? OPC_LUI : (r[1:0] == 2'd1 ? OPC_OP_IMM : OPC_OP);
    // sub and sra need bit 30, register and shift forms need the rest clear
    if (inst.opcode == OPC_OP || (inst.opcode == OPC_OP_IMM && inst.funct3[1:0] == 2'b01)) begin
      inst.funct7 = {1'b0, r[6] && (inst.funct3 == F3_SRL_SRA || inst.funct3 == F3_ADD_SUB
                    && inst.opcode == OPC_OP), 5'b0};
    end
    if (r[5:2] == 4'd0) begin
      inst.opcode = 7'b1100011;
    end
    return inst;
  endfunction

  // ======================================================================
  // reference model
  // ======================================================================
  function automatic logic writes_reg(rv_inst_t inst);
    return (inst.opcode == OPC_OP || inst.opcode == OPC_OP_IMM || inst.opcode == OPC_LUI)
           && inst.rd != 5'd0;
  endfunction

  function automatic logic [31:0] ref_result(rv_inst_t inst);
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  sh;
    logic        alt;
    if (inst.opcode == OPC_LUI) begin
      return {inst[31:12], 12'h000};
    end
    a = model_regs[inst.rs1];
    // only srai reads bit 30 of the immediate
    if (inst.opcode == OPC_OP) begin
      b = model_regs[inst.rs2];
      alt = inst.funct7[5];
    end else begin
      b = {{20{inst[31]}}, inst[31:20]};
      alt = inst.funct7[5] && inst.funct3 == F3_SRL_SRA;
    end
    sh = b[4:0];
    case (inst.funct3)
      F3_ADD_SUB: return alt ? a + ~b + 32'd1 : a + b;
      F3_SLL:     return a << sh;
      F3_SLT:     return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
      F3_SLTU:    return {31'b0, a < b};
      F3_XOR:     return a ^ b;
      F3_SRL_SRA: return (alt && a[31]) ? (a >> sh) | ~(32'hFFFF_FFFF >> sh) : a >> sh;
      F3_OR:      return a | b;
      default:    return a & b;
    endcase
  endfunction

  // ======================================================================
  // checks and sequencing
  // ======================================================================
  task automatic check_wb(string name, wb_t exp, wb_t act);
    check_cnt++;
    if (act !== exp) begin
      $display("Mismatch %s: expected x%0d=%h, actual x%0d=%h",
               name, exp.rd, exp.data, act.rd, act.data);
      err_cnt++;
    end
  endtask

  task automatic check_valid(string name, logic exp, logic act);
    check_cnt++;
    if (act !== exp) begin
      $display("Mismatch %s: expected wb_valid %b, actual %b", name, exp, act);
      err_cnt++;
    end
  endtask

  // strobe due two edges after the sampling edge
  task automatic send_inst(rv_inst_t inst);
    wb_t exp;
    @(negedge clk_i);
    inst_valid_i = 1'b1;
    inst_i = inst;
    if (writes_reg(inst)) begin
      exp.rd = inst.rd;
      exp.data = ref_result(inst);
      exp_q.push_back(exp);
      exp_cyc_q.push_back(cycle_cnt + 3);
      model_regs[inst.rd] = exp.data;
    end
  endtask

  task automatic idle_cycles(int n);
    repeat (n) begin
      @(negedge clk_i);
      inst_valid_i = 1'b0;
      inst_i = '0;
    end
  endtask

  task automatic begin_test(string name);
    cur_test = name;
    test_err_base = err_cnt;
  endtask

  task automatic end_test();
    int waited;
    idle_cycles(1);
    waited = 0;
    while (exp_q.size() != 0 && waited < 40) begin
      @(negedge clk_i);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("%s: timeout, %0d expected results never arrived", cur_test, exp_q.size());
      err_cnt++;
      exp_q.delete();
      exp_cyc_q.delete();
    end
    // room for a late stray strobe
    idle_cycles(4);
    tests_run++;
    if (err_cnt == test_err_base) begin
      $display("test %s: passed", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", cur_test, err_cnt - test_err_base);
    end
  endtask

  // write-back monitor on the falling edge
  always @(negedge clk_i) begin
    if (!rst_n_i) begin
      if (wb_valid_o !== 1'b0) begin
        $display("%s: write strobe raised during reset", cur_test);
        err_cnt++;
      end
    end else if (wb_valid_o === 1'b1) begin
      if (exp_cyc_q.size() == 0 || exp_cyc_q[0] > cycle_cnt) begin
        $display("%s: write strobe for x%0d with no result due", cur_test, wb_o.rd);
        err_cnt++;
      end else begin
        check_wb(cur_test, exp_q.pop_front(), wb_o);
        if (exp_cyc_q[0] != cycle_cnt) begin
          $display("%s: result arrived in cycle %0d, due in cycle %0d",
                   cur_test, cycle_cnt, exp_cyc_q[0]);
          err_cnt++;
        end
        void'(exp_cyc_q.pop_front());
      end
    end else if (wb_valid_o !== 1'b0) begin
      $display("%s: write strobe is unknown", cur_test);
      err_cnt++;
    end
  end

  // ======================================================================
  // test sequence
  // ======================================================================
  initial begin
    logic [31:0] rnd;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [4:0]  tgt;
    rv_inst_t    bad;
    rst_n_i = 1'b0;
    inst_valid_i = 1'b0;
    inst_i = '0;
    rng_state = 32'h1533_3074;
    for (int r = 0; r < `RV_NUM_REGS; r++) begin
      model_regs[r] = '0;
    end
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    begin_test("reset_state");
    for (int n = 0; n < 6; n++) begin
      @(negedge clk_i);
      check_valid(cur_test, 1'b0, wb_valid_o);
    end
    send_inst(r_inst(F3_ADD_SUB, 1'b0, 5'd5, 5'd3, 5'd4));
    send_inst(i_inst(F3_OR, 12'h000, 5'd6, 5'd7));
    end_test();

    begin_test("register_ops");
    for (int r = 1; r < `RV_NUM_REGS; r++) begin
      rnd = next_rand();
      send_inst(u_inst(rnd[31:12], 5'(r)));
      send_inst(i_inst(F3_ADD_SUB, rnd[11:0], 5'(r), 5'(r)));
    end
    send_inst(u_inst(20'hF0F0F, 5'd10));
    send_inst(r_inst(F3_SRL_SRA, 1'b1, 5'd11, 5'd10, 5'd3));
    send_inst(r_inst(F3_SLT, 1'b0, 5'd12, 5'd10, 5'd13));
    send_inst(r_inst(F3_SLTU, 1'b0, 5'd14, 5'd10, 5'd13));
    for (int n = 0; n < 48; n++) begin
      f3 = 3'(n);
      send_inst(r_inst(f3, (n % 16 >= 8) && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA),
                       rand_reg(), rand_reg(), rand_reg()));
    end
    end_test();

    begin_test("imm_ops");
    send_inst(u_inst(20'h8F00F, 5'd10));
    send_inst(i_inst(F3_SLTU, 12'hFFF, 5'd20, 5'd10));
    send_inst(i_inst(F3_SLT, 12'h800, 5'd21, 5'd10));
    send_inst(i_inst(F3_SRL_SRA, 12'h41F, 5'd22, 5'd10));
    for (int n = 0; n < 36; n++) begin
      rnd = next_rand();
      f3 = 3'(n);
      imm = rnd[11:0];
      if (f3 == F3_SLL || f3 == F3_SRL_SRA) begin
        // shift amounts 0 and 31 come first
        imm[4:0] = (n < 8) ? 5'd0 : (n < 16 ? 5'd31 : rnd[4:0]);
        imm[11:5] = {1'b0, f3 == F3_SRL_SRA && rnd[5], 5'b0};
      end
      send_inst(i_inst(f3, imm, rand_reg(), rand_reg()));
    end
    end_test();

    begin_test("forwarding");
    for (int d = 1; d <= 3; d++) begin
      tgt = 5'(5 + d);
      for (int n = 0; n < 8; n++) begin
        rnd = next_rand();
        f3 = rnd[8] ? F3_XOR : F3_ADD_SUB;
        if (n % 2 == 1) begin
          send_inst(r_inst(f3, rnd[9] && f3 == F3_ADD_SUB, tgt, 5'd20, tgt));
        end else begin
          send_inst(r_inst(f3, rnd[9] && f3 == F3_ADD_SUB, tgt, tgt, 5'd21));
        end
        // independent fillers set the distance
        for (int f = 0; f < d - 1; f++) begin
          send_inst(r_inst(F3_OR, 1'b0, 5'(25 + f), 5'd22, 5'd23));
        end
      end
    end
    end_test();

    begin_test("x0_and_unknown");
    send_inst(r_inst(F3_ADD_SUB, 1'b0, 5'd0, 5'd1, 5'd2));
    send_inst(i_inst(F3_OR, 12'h5A5, 5'd0, 5'd3));
    send_inst(u_inst(20'hABCDE, 5'd0));
    bad = r_inst(F3_ADD_SUB, 1'b0, 5'd9, 5'd1, 5'd2);
    bad.opcode = 7'b0000011;
    send_inst(bad);
    bad.opcode = 7'b1101111;
    send_inst(bad);
    send_inst(r_inst(F3_OR, 1'b0, 5'd10, 5'd9, 5'd0));
    send_inst(i_inst(F3_ADD_SUB, 12'h000, 5'd11, 5'd0));
    end_test();

    begin_test("random_mix");
    for (int n = 0; n < 60; n++) begin
      send_inst(rand_inst());
      idle_cycles(int'(next_rand() % 4));
    end
    end_test();

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, check_cnt, err_cnt);
    if (err_cnt == 0 && tests_failed == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== test/rv_core_assert.sv ====
`timescale 1ns/1ns

module rv_core_assert
  import rv_pipe_pkg::*;
(
  input logic clk_i,
  input logic rst_n_i,
  input logic wb_valid_i,
  input wb_t  wb_i
);

  // no write-back while the core is held in reset
  a_quiet_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !wb_valid_i)
    else $error("write-back strobe while reset is held");

  // x0 writes are dropped in decode
  a_rd_nonzero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_valid_i |-> wb_i.rd != '0)
    else $error("write-back strobe addressed to x0");

  a_data_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_valid_i |-> !$isunknown(wb_i.data))
    else $error("write-back data is unknown");

endmodule

bind rv_core_top rv_core_assert u_assert (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .wb_valid_i (wb_valid_o),
  .wb_i       (wb_o)
);

// ==== verilog/rv_core_top.sv ====
`timescale 1ns/1ns
`include "rv_core_params.svh"

module rv_core_top
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     inst_valid_i,
  input  rv_inst_t inst_i,
  output logic     wb_valid_o,
  output wb_t      wb_o
);

  logic [`RV_REG_AW-1:0] rs1;
  logic [`RV_REG_AW-1:0] rs2;
  logic [`RV_XLEN-1:0]   rdata1;
  logic [`RV_XLEN-1:0]   rdata2;
  id_exe_t               id_exe;

  // ======================================================================
  // decode
  // ======================================================================
  decode_stage u_decode (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .rdata1_i     (rdata1),
    .rdata2_i     (rdata2),
    .rs1_o        (rs1),
    .rs2_o        (rs2),
    .id_exe_o     (id_exe)
  );

  // ======================================================================
  // execute
  // ======================================================================
  execute_stage u_execute (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .id_exe_i   (id_exe),
    .wb_valid_o (wb_valid_o),
    .wb_o       (wb_o)
  );

  // register file, written by the write-back strobe
  reg_file u_reg_file (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .raddr1_i (rs1),
    .raddr2_i (rs2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .we_i     (wb_valid_o),
    .wb_i     (wb_o)
  );

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ns
`include "rv_core_params.svh"

module execute_stage
  import rv_pipe_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  id_exe_t id_exe_i,
  output logic    wb_valid_o,
  output wb_t     wb_o
);

  logic                fwd1;
  logic                fwd2;
  logic [`RV_XLEN-1:0] op1;
  logic [`RV_XLEN-1:0] rs2_val;
  logic [`RV_XLEN-1:0] op2;
  logic [`RV_XLEN-1:0] alu_res;
  logic                wb_valid_q;
  wb_t                 wb_q;

  // ======================================================================
  // operand forwarding
  // ======================================================================

  // wb_valid is only set for a nonzero rd, so x0 never forwards
  assign fwd1 = wb_valid_q && (wb_q.rd == id_exe_i.rs1);
  assign fwd2 = wb_valid_q && (wb_q.rd == id_exe_i.rs2);

  assign op1     = fwd1 ? wb_q.data : id_exe_i.rdata1;
  assign rs2_val = fwd2 ? wb_q.data : id_exe_i.rdata2;

  // immediate forms take operand 2 from decode
  assign op2 = id_exe_i.use_imm ? id_exe_i.imm : rs2_val;

  alu u_alu (
    .op_i     (id_exe_i.alu_op),
    .a_i      (op1),
    .b_i      (op2),
    .result_o (alu_res)
  );

  // ======================================================================
  // write-back register
  // ======================================================================
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_valid_q <= 1'b0;
    end else begin
      wb_valid_q <= id_exe_i.valid && id_exe_i.wr_en;
    end
  end

  // result payload, held between writes
  always_ff @(posedge clk_i) begin
    if (id_exe_i.valid && id_exe_i.wr_en) begin
      wb_q.rd   <= id_exe_i.rd;
      wb_q.data <= alu_res;
    end
  end

  assign wb_valid_o = wb_valid_q;
  assign wb_o       = wb_q;

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ns
`include "rv_core_params.svh"

module decode_stage
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  inst_valid_i,
  input  rv_inst_t              inst_i,
  input  logic [`RV_XLEN-1:0]   rdata1_i,
  input  logic [`RV_XLEN-1:0]   rdata2_i,
  output logic [`RV_REG_AW-1:0] rs1_o,
  output logic [`RV_REG_AW-1:0] rs2_o,
  output id_exe_t               id_exe_o
);

  rv_inst_t            inst_q;
  logic                inst_valid_q;
  opcode_e             opcode;
  funct3_e             funct3;
  logic                legal_op;
  logic                use_imm;
  alu_op_e             alu_op;
  logic [`RV_XLEN-1:0] imm;
  id_exe_t             id_exe_d;

  // funct3 plus the alternate bit to an alu operation
  function automatic alu_op_e sel_alu_op(funct3_e f3, logic alt);
    alu_op_e op;
    op = ALU_ADD;
    case (f3)
      F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     op = ALU_SLL;
      F3_SLT:     op = ALU_SLT;
      F3_SLTU:    op = ALU_SLTU;
      F3_XOR:     op = ALU_XOR;
      F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      op = ALU_OR;
      F3_AND:     op = ALU_AND;
    endcase
    return op;
  endfunction

  // ======================================================================
  // instruction capture
  // ======================================================================
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      inst_valid_q <= 1'b0;
    end else begin
      inst_valid_q <= inst_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (inst_valid_i) begin
      inst_q <= inst_i;
    end
  end

  // ======================================================================
  // decode and immediate
  // ======================================================================
  assign opcode = opcode_e'(inst_q.opcode);
  assign funct3 = funct3_e'(inst_q.funct3);

  always_comb begin
    legal_op = 1'b0;
    use_imm  = 1'b0;
    alu_op   = ALU_ADD;
    imm      = '0;
    rs1_o    = inst_q.rs1;
    case (opcode)
      OPC_OP: begin
        legal_op = 1'b1;
        alu_op   = sel_alu_op(funct3, inst_q.funct7[5]);
      end
      OPC_OP_IMM: begin
        legal_op = 1'b1;
        use_imm  = 1'b1;
        // only the right shift reads imm[10] as the alternate bit
        alu_op   = sel_alu_op(funct3, (funct3 == F3_SRL_SRA) && inst_q.funct7[5]);
        if (funct3 == F3_SLL || funct3 == F3_SRL_SRA) begin
          imm = {{(`RV_XLEN-`RV_REG_AW){1'b0}}, inst_q.rs2};
        end else begin
          imm = {{(`RV_XLEN-12){inst_q.funct7[6]}}, inst_q.funct7, inst_q.rs2};
        end
      end
      OPC_LUI: begin
        // x0 + upper immediate
        legal_op = 1'b1;
        use_imm  = 1'b1;
        rs1_o    = '0;
        imm      = {inst_q.funct7, inst_q.rs2, inst_q.rs1, inst_q.funct3, 12'b0};
      end
      default: ;
    endcase
  end

  assign rs2_o = inst_q.rs2;

  always_comb begin
    id_exe_d.valid   = inst_valid_q;
    id_exe_d.wr_en   = legal_op && (inst_q.rd != '0);
    id_exe_d.rd      = inst_q.rd;
    id_exe_d.rs1     = rs1_o;
    id_exe_d.rs2     = rs2_o;
    id_exe_d.alu_op  = alu_op;
    id_exe_d.use_imm = use_imm;
    id_exe_d.rdata1  = rdata1_i;
    id_exe_d.rdata2  = rdata2_i;
    id_exe_d.imm     = imm;
  end

  // id/exe pipeline register
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      id_exe_o <= '0;
    end else begin
      id_exe_o <= id_exe_d;
    end
  end

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ns
`include "rv_core_params.svh"

module reg_file
  import rv_pipe_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [`RV_REG_AW-1:0] raddr1_i,
  input  logic [`RV_REG_AW-1:0] raddr2_i,
  output logic [`RV_XLEN-1:0]   rdata1_o,
  output logic [`RV_XLEN-1:0]   rdata2_o,
  input  logic                  we_i,
  input  wb_t                   wb_i
);

  // no storage for x0
  logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

  // write-first read port for the distance-2 hazard
  function automatic logic [`RV_XLEN-1:0] read_port(logic [`RV_REG_AW-1:0] addr);
    if (addr == '0) begin
      return '0;
    end
    if (we_i && addr == wb_i.rd) begin
      return wb_i.data;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rdata1_o = read_port(raddr1_i);
    rdata2_o = read_port(raddr2_i);
  end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ns
`include "rv_core_params.svh"

module alu
  import rv_isa_pkg::*;
(
  input  alu_op_e             op_i,
  input  logic [`RV_XLEN-1:0] a_i,
  input  logic [`RV_XLEN-1:0] b_i,
  output logic [`RV_XLEN-1:0] result_o
);

  localparam int SHW = $clog2(`RV_XLEN);

  logic [SHW-1:0] shamt;
  logic           lt_signed;
  logic           lt_unsigned;

  // shift amount from the low bits only
  assign shamt = b_i[SHW-1:0];

  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  always_comb begin
    case (op_i)
      ALU_ADD:  result_o = a_i + b_i;
      ALU_SUB:  result_o = a_i - b_i;
      ALU_SLL:  result_o = a_i << shamt;
      ALU_SLT:  result_o = {{(`RV_XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: result_o = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:  result_o = a_i ^ b_i;
      ALU_SRL:  result_o = a_i >> shamt;
      // arithmetic shift keeps the sign bit
      ALU_SRA:  result_o = $unsigned($signed(a_i) >>> shamt);
      ALU_OR:   result_o = a_i | b_i;
      ALU_AND:  result_o = a_i & b_i;
      default:  result_o = a_i + b_i;
    endcase
  end

endmodule

// ==== verilog/rv_pipe_pkg.sv ====
`include "rv_core_params.svh"

package rv_pipe_pkg;

  import rv_isa_pkg::*;

  // ======================================================================
  // stage payloads
  // ======================================================================

  // decode to execute
  typedef struct packed {
    logic                  valid;
    logic                  wr_en;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_REG_AW-1:0] rs1;
    logic [`RV_REG_AW-1:0] rs2;
    alu_op_e               alu_op;
    logic                  use_imm;
    logic [`RV_XLEN-1:0]   rdata1;
    logic [`RV_XLEN-1:0]   rdata2;
    logic [`RV_XLEN-1:0]   imm;
  } id_exe_t;

  // execute to write-back / register file
  typedef struct packed {
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   data;
  } wb_t;

endpackage

// ==== verilog/rv_isa_pkg.sv ====
`include "rv_core_params.svh"

package rv_isa_pkg;

  // ======================================================================
  // instruction encoding
  // ======================================================================

  // major opcodes still decoded by this core
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111
  } opcode_e;

  // funct3 codes shared by OP and OP-IMM
  typedef enum logic [2:0] {
    F3_ADD_SUB = 3'b000,
    F3_SLL     = 3'b001,
    F3_SLT     = 3'b010,
    F3_SLTU    = 3'b011,
    F3_XOR     = 3'b100,
    F3_SRL_SRA = 3'b101,
    F3_OR      = 3'b110,
    F3_AND     = 3'b111
  } funct3_e;

  // alu operation, top bit mirrors funct7[5]
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  // r-type field layout, msb first
  typedef struct packed {
    logic [6:0]            funct7;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    logic [6:0]            opcode;
  } rv_inst_t;

endpackage

// ==== verilog/rv_core_params.svh ====
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// ======================================================================
// core dimensions
// ======================================================================

// data path width
`define RV_XLEN 32

// register index width, matches the rd/rs1/rs2 fields
`define RV_REG_AW 5

// architectural registers including x0
`define RV_NUM_REGS 32

`endif
